/* hdl/soc_pkg.sv */
package soc_pkg;

	// Basic bus widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;
	typedef logic [15:0] word_addr_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// Address map, region picked by the top three bits
	localparam addr_t REGION_MASK = 32'he000_0000;
	localparam addr_t SRAM_BASE   = 32'h0000_0000;
	localparam addr_t TIMER_BASE  = 32'h4000_0000;

	// Timer register byte offsets
	localparam addr_t TIMER_CTRL  = 32'h0000_0000;
	localparam addr_t MTIME_LO    = 32'h0000_0008;
	localparam addr_t MTIME_HI    = 32'h0000_000c;
	localparam addr_t MTIMECMP_LO = 32'h0000_0010;
	localparam addr_t MTIMECMP_HI = 32'h0000_0014;

	typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} region_t;

	// Master side of the AXI4-Lite port
	typedef struct packed {
		addr_t awaddr;
		logic  awvalid;
		data_t wdata;
		strb_t wstrb;
		logic  wvalid;
		logic  bready;
		addr_t araddr;
		logic  arvalid;
		logic  rready;
	} axil_req_t;

	// Slave side of the AXI4-Lite port
	typedef struct packed {
		logic  awready;
		logic  wready;
		resp_t bresp;
		logic  bvalid;
		logic  arready;
		data_t rdata;
		resp_t rresp;
		logic  rvalid;
	} axil_rsp_t;

	// One access towards a target
	typedef struct packed {
		logic       write;
		word_addr_t word_addr;
		data_t      wdata;
		strb_t      wstrb;
	} periph_req_t;

endpackage

/* hdl/axil_decoder.sv */
module axil_decoder (
	input  logic                 clk,
	input  logic                 rst_n,
	input  soc_pkg::axil_req_t   axil_req,
	output soc_pkg::axil_rsp_t   axil_rsp,
	output soc_pkg::periph_req_t periph_req,
	output logic                 sram_sel,
	output logic                 timer_sel,
	input  soc_pkg::data_t       sram_rdata,
	input  soc_pkg::data_t       timer_rdata
);
	import soc_pkg::*;

	region_t state;
	logic    is_write;
	logic    sram_hit;
	logic    timer_hit;
	resp_t   resp;

	logic    rd_accept;
	logic    wr_accept;
	addr_t   acc_addr;
	logic    acc_sram;
	logic    acc_timer;
	logic    resp_taken;

	// ------------------------------
	// Accept and decode

	// Only IDLE takes a new request, a read beats a write
	assign rd_accept = (state == IDLE) && axil_req.arvalid;
	assign wr_accept = (state == IDLE) && axil_req.awvalid && axil_req.wvalid
		&& !axil_req.arvalid;

	assign acc_addr  = rd_accept ? axil_req.araddr : axil_req.awaddr;
	assign acc_sram  = (acc_addr & REGION_MASK) == SRAM_BASE;
	assign acc_timer = (acc_addr & REGION_MASK) == TIMER_BASE;

	assign resp_taken = is_write ? axil_req.bready : axil_req.rready;

	// ------------------------------
	// Transaction FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			is_write  <= 1'b0;
			sram_hit  <= 1'b0;
			timer_hit <= 1'b0;
			resp      <= RESP_OKAY;
		end else begin
			case (state)
				IDLE: begin
					if (rd_accept || wr_accept) begin
						state     <= ACCESS;
						is_write  <= wr_accept;
						sram_hit  <= acc_sram;
						timer_hit <= acc_timer;
						// Unmapped addresses still walk the FSM, just with an error
						resp      <= (acc_sram || acc_timer) ? RESP_OKAY : RESP_SLVERR;
					end
				end
				ACCESS: begin
					state <= RESPOND;
				end
				RESPOND: begin
					if (resp_taken) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Request towards the targets, held until the next accept
	always_ff @(posedge clk) begin
		if (rd_accept || wr_accept) begin
			periph_req.write     <= wr_accept;
			periph_req.word_addr <= acc_addr[2 +: $bits(word_addr_t)];
			periph_req.wdata     <= axil_req.wdata;
			periph_req.wstrb     <= wr_accept ? axil_req.wstrb : '0;
		end
	end

	// One cycle strobe per access
	assign sram_sel  = (state == ACCESS) && sram_hit;
	assign timer_sel = (state == ACCESS) && timer_hit;

	// ------------------------------
	// Response channel

	always_comb begin
		axil_rsp         = '0;
		axil_rsp.awready = wr_accept;
		axil_rsp.wready  = wr_accept;
		axil_rsp.arready = rd_accept;
		axil_rsp.bvalid  = (state == RESPOND) && is_write;
		axil_rsp.bresp   = resp;
		axil_rsp.rvalid  = (state == RESPOND) && !is_write;
		axil_rsp.rresp   = resp;
		// Targets hold their read word until their next select
		if (sram_hit) begin
			axil_rsp.rdata = sram_rdata;
		end else if (timer_hit) begin
			axil_rsp.rdata = timer_rdata;
		end else begin
			axil_rsp.rdata = '0;
		end
	end

endmodule

/* hdl/sram_store.sv */
module sram_store #(
	parameter int SRAM_DEPTH = 1024
) (
	input  logic                 clk,
	input  logic                 sel,
	input  soc_pkg::periph_req_t periph_req,
	output soc_pkg::data_t       rdata
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(SRAM_DEPTH);

	data_t            mem [SRAM_DEPTH];
	logic [IDX_W-1:0] idx;

	// Word offset wraps at the memory depth
	assign idx = periph_req.word_addr[IDX_W-1:0];

	// ------------------------------
	// Byte lane writes

	always_ff @(posedge clk) begin
		if (sel && periph_req.write) begin
			for (int i = 0; i < $bits(strb_t); i++) begin
				if (periph_req.wstrb[i]) begin
					mem[idx][i*8 +: 8] <= periph_req.wdata[i*8 +: 8];
				end
			end
		end
	end

	// ------------------------------
	// Registered read port

	// Read word only changes on a select, so it stays put under back-pressure
	always_ff @(posedge clk) begin
		if (sel) begin
			rdata <= mem[idx];
		end
	end

endmodule

/* hdl/mtimer.sv */
module mtimer #(
	parameter int CLK_MHZ = 12
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 sel,
	input  soc_pkg::periph_req_t periph_req,
	output soc_pkg::data_t       rdata,
	output logic                 timer_irq
);
	import soc_pkg::*;

	localparam int TICK_W = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

	logic [TICK_W-1:0] tick_ctr;
	logic              tick;

	logic              ctrl_en;
	logic [63:0]       mtime;
	logic [63:0]       mtimecmp;

	addr_t             byte_off;
	logic              wr;

	// Merge a bus write into a register, one byte per strobe bit
	function automatic data_t merge_strb(data_t old, data_t wdata, strb_t wstrb);
		data_t result;
		result = old;
		for (int i = 0; i < $bits(strb_t); i++) begin
			if (wstrb[i]) begin
				result[i*8 +: 8] = wdata[i*8 +: 8];
			end
		end
		return result;
	endfunction

	// ------------------------------
	// Microsecond timebase

	// Counts CLK_MHZ-1 down to 0, tick fires once per wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
			tick     <= 1'b0;
		end else begin
			if (tick_ctr != '0) begin
				tick_ctr <= tick_ctr - 1'b1;
			end else begin
				tick_ctr <= TICK_W'(CLK_MHZ - 1);
			end
			tick <= (tick_ctr == '0);
		end
	end

	// ------------------------------
	// Register file

	assign byte_off = addr_t'({periph_req.word_addr, 2'b00});
	assign wr       = sel && periph_req.write;

	// A bus write to mtime takes priority over the tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en  <= 1'b0;
			mtime    <= '0;
			mtimecmp <= '1;
		end else begin
			if (ctrl_en && tick) begin
				mtime <= mtime + 64'd1;
			end
			if (wr) begin
				case (byte_off)
					TIMER_CTRL: begin
						if (periph_req.wstrb[0]) begin
							ctrl_en <= periph_req.wdata[0];
						end
					end
					MTIME_LO: mtime[31:0] <= merge_strb(mtime[31:0], periph_req.wdata,
						periph_req.wstrb);
					MTIME_HI: mtime[63:32] <= merge_strb(mtime[63:32], periph_req.wdata,
						periph_req.wstrb);
					MTIMECMP_LO: mtimecmp[31:0] <= merge_strb(mtimecmp[31:0],
						periph_req.wdata, periph_req.wstrb);
					MTIMECMP_HI: mtimecmp[63:32] <= merge_strb(mtimecmp[63:32],
						periph_req.wdata, periph_req.wstrb);
					default: begin
					end
				endcase
			end
		end
	end

	// Read word held between selects
	always_ff @(posedge clk) begin
		if (sel) begin
			case (byte_off)
				TIMER_CTRL:  rdata <= {31'd0, ctrl_en};
				MTIME_LO:    rdata <= mtime[31:0];
				MTIME_HI:    rdata <= mtime[63:32];
				MTIMECMP_LO: rdata <= mtimecmp[31:0];
				MTIMECMP_HI: rdata <= mtimecmp[63:32];
				default:     rdata <= '0;
			endcase
		end
	end

	// ------------------------------
	// Interrupt

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= ctrl_en && (mtime >= mtimecmp);
		end
	end

endmodule

/* hdl/soc_top.sv */
module soc_top #(
	parameter int SRAM_DEPTH = 1024,
	parameter int CLK_MHZ    = 12
) (
	input  logic               clk,
	input  logic               rst_n,
	input  soc_pkg::axil_req_t axil_req,
	output soc_pkg::axil_rsp_t axil_rsp,
	output logic               timer_irq
);
	import soc_pkg::*;

	periph_req_t periph_req;
	logic        sram_sel;
	logic        timer_sel;
	data_t       sram_rdata;
	data_t       timer_rdata;

	// ------------------------------
	// Bus decode

	axil_decoder decoder_u (
		.clk         (clk),
		.rst_n       (rst_n),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.periph_req  (periph_req),
		.sram_sel    (sram_sel),
		.timer_sel   (timer_sel),
		.sram_rdata  (sram_rdata),
		.timer_rdata (timer_rdata)
	);

	// ------------------------------
	// Memory and timer

	// SRAM at 0x0000_0000
	sram_store #(
		.SRAM_DEPTH (SRAM_DEPTH)
	) sram_u (
		.clk        (clk),
		.sel        (sram_sel),
		.periph_req (periph_req),
		.rdata      (sram_rdata)
	);

	// Machine timer at 0x4000_0000
	mtimer #(
		.CLK_MHZ (CLK_MHZ)
	) timer_u (
		.clk        (clk),
		.rst_n      (rst_n),
		.sel        (timer_sel),
		.periph_req (periph_req),
		.rdata      (timer_rdata),
		.timer_irq  (timer_irq)
	);

endmodule

/* tests/tb_soc_top.sv */
module tb_soc_top;
	timeunit 1ns;
	timeprecision 100ps;
	import soc_pkg::*;

	localparam int SRAM_DEPTH = 256;
	localparam int CLK_MHZ    = 4;
	localparam logic [1:0] OP_WRITE = 2'd0;
	localparam logic [1:0] OP_READ  = 2'd1;
	localparam logic [1:0] OP_IDLE  = 2'd2;

	typedef struct packed {
		logic [1:0] op;
		addr_t      addr;
		data_t      wdata;
		strb_t      wstrb;
		data_t      exp_data;
		resp_t      exp_resp;
	} entry_t;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	axil_req_t   axil_req = '0;
	axil_rsp_t   axil_rsp;
	logic        timer_irq;

	entry_t      tbl[$];
	logic [31:0] lfsr = 32'h7928bccb;
	int          cycles = 0;
	int          cycle_limit = 100000;
	int          test_errs = 0;
	int          pass_count = 0;
	int          fail_count = 0;

	soc_top #(
		.SRAM_DEPTH (SRAM_DEPTH),
		.CLK_MHZ    (CLK_MHZ)
	) DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.timer_irq (timer_irq)
	);

	always #10 clk = ~clk;

	// Ends the run if a handshake never completes
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------
	// Helpers

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return b;
	endfunction

	function automatic logic rsp_valid(logic wr);
		return wr ? axil_rsp.bvalid : axil_rsp.rvalid;
	endfunction

	function automatic resp_t rsp_code(logic wr);
		return wr ? axil_rsp.bresp : axil_rsp.rresp;
	endfunction

	task automatic report_mismatch(string sig, data_t got, data_t exp);
		$display("[FAIL] time %0t: %s got %h expected %h", $time, sig, got, exp);
		test_errs++;
	endtask

	task automatic report_error(string msg);
		$display("Error at time %0t: %s", $time, msg);
		test_errs++;
	endtask

	task automatic finish_test(string name);
		if (test_errs == 0) begin
			pass_count++;
			$display("pass  %s", name);
		end else begin
			fail_count++;
			$display("fail  %s, %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	function automatic void add_entry(logic [1:0] op, addr_t addr, data_t wdata, strb_t wstrb,
		data_t exp_data, resp_t exp_resp);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.wdata    = wdata;
		e.wstrb    = wstrb;
		e.exp_data = exp_data;
		e.exp_resp = exp_resp;
		tbl.push_back(e);
	endfunction

	// ------------------------------
	// AXI4-Lite master

	task automatic bus_xfer(input logic wr, input addr_t addr, input data_t wdata,
		input strb_t wstrb, output data_t rdata, output resp_t resp);
		int         wait_n;
		logic       seen;
		logic [1:0] dly;
		data_t      hold_data;
		resp_t      hold_resp;
		@(posedge clk);
		if (wr) begin
			axil_req.awaddr  <= addr;
			axil_req.awvalid <= 1'b1;
			axil_req.wdata   <= wdata;
			axil_req.wstrb   <= wstrb;
			axil_req.wvalid  <= 1'b1;
		end else begin
			axil_req.araddr  <= addr;
			axil_req.arvalid <= 1'b1;
		end
		wait_n = 0;
		do begin
			@(negedge clk);
			wait_n++;
			seen = wr ? (axil_rsp.awready && axil_rsp.wready) : axil_rsp.arready;
		end while (!seen && wait_n < 16);
		if (!seen) report_error("address handshake never completed");
		@(posedge clk);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		axil_req.arvalid <= 1'b0;
		// Response is due 2 cycles after the handshake cycle
		wait_n = 0;
		do begin
			@(negedge clk);
			wait_n++;
		end while (!rsp_valid(wr) && wait_n < 16);
		if (!rsp_valid(wr)) report_error("no response after the address handshake");
		else if (wait_n != 2) report_mismatch("response latency", wait_n, 2);
		hold_data = axil_rsp.rdata;
		hold_resp = rsp_code(wr);
		dly[1] = lfsr_bit();
		dly[0] = lfsr_bit();
		// Back-pressure while new requests are offered on both channels
		for (int i = 0; i < int'(dly); i++) begin
			@(posedge clk);
			axil_req.awvalid <= 1'b1;
			axil_req.wvalid  <= 1'b1;
			axil_req.wstrb   <= '0;
			axil_req.arvalid <= 1'b1;
			@(negedge clk);
			if (axil_rsp.awready || axil_rsp.arready) report_error("request taken while busy");
			if (!rsp_valid(wr)) report_error("valid dropped before ready");
			if (rsp_code(wr) !== hold_resp) report_mismatch("resp", data_t'(rsp_code(wr)),
				data_t'(hold_resp));
			if (!wr && axil_rsp.rdata !== hold_data) report_mismatch("rdata", axil_rsp.rdata,
				hold_data);
		end
		@(posedge clk);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		axil_req.arvalid <= 1'b0;
		axil_req.bready  <= wr;
		axil_req.rready  <= !wr;
		@(negedge clk);
		if (!rsp_valid(wr)) report_error("valid dropped before ready");
		rdata = axil_rsp.rdata;
		resp  = rsp_code(wr);
		@(posedge clk);
		axil_req.bready <= 1'b0;
		axil_req.rready <= 1'b0;
	endtask

	task automatic run_entry(entry_t e);
		data_t rdata;
		resp_t resp;
		if (e.op == OP_IDLE) begin
			repeat (e.wdata) @(posedge clk);
		end else begin
			bus_xfer(e.op == OP_WRITE, e.addr, e.wdata, e.wstrb, rdata, resp);
			if (resp !== e.exp_resp) report_mismatch("resp", data_t'(resp), data_t'(e.exp_resp));
			if (e.op == OP_READ && rdata !== e.exp_data) report_mismatch("rdata", rdata,
				e.exp_data);
		end
	endtask

	// ------------------------------
	// Stimulus

	initial begin
		data_t rdata;
		resp_t resp;
		int    wait_n;
		// SRAM words including the last word of a 256 word memory
		add_entry(OP_WRITE, 32'h0000_0000, 32'hdead_beef, 4'hf, '0, RESP_OKAY);
		add_entry(OP_WRITE, 32'h0000_0004, 32'h0123_4567, 4'hf, '0, RESP_OKAY);
		add_entry(OP_WRITE, 32'h0000_03fc, 32'ha5a5_5a5a, 4'hf, '0, RESP_OKAY);
		add_entry(OP_READ, 32'h0000_0000, '0, '0, 32'hdead_beef, RESP_OKAY);
		add_entry(OP_READ, 32'h0000_0004, '0, '0, 32'h0123_4567, RESP_OKAY);
		add_entry(OP_READ, 32'h0000_03fc, '0, '0, 32'ha5a5_5a5a, RESP_OKAY);
		// Byte lane 2 only
		add_entry(OP_WRITE, 32'h0000_0010, 32'h1122_3344, 4'hf, '0, RESP_OKAY);
		add_entry(OP_WRITE, 32'h0000_0010, 32'haabb_ccdd, 4'b0100, '0, RESP_OKAY);
		add_entry(OP_READ, 32'h0000_0010, '0, '0, 32'h11bb_3344, RESP_OKAY);
		// Unmapped regions
		add_entry(OP_WRITE, 32'h8000_0000, 32'h0bad_0bad, 4'hf, '0, RESP_SLVERR);
		add_entry(OP_READ, 32'h8000_0000, '0, '0, '0, RESP_SLVERR);
		add_entry(OP_WRITE, 32'h2000_0000, 32'h0bad_0bad, 4'hf, '0, RESP_SLVERR);
		add_entry(OP_READ, 32'h2000_0000, '0, '0, '0, RESP_SLVERR);
		add_entry(OP_READ, 32'h0000_0000, '0, '0, 32'hdead_beef, RESP_OKAY);
		// Timer reset values and mtime idle while disabled
		add_entry(OP_READ, TIMER_BASE + TIMER_CTRL, '0, '0, '0, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + MTIME_LO, '0, '0, '0, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + MTIME_HI, '0, '0, '0, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + MTIMECMP_LO, '0, '0, 32'hffff_ffff, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + MTIMECMP_HI, '0, '0, 32'hffff_ffff, RESP_OKAY);
		add_entry(OP_IDLE, '0, 32'd100, '0, '0, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + MTIME_LO, '0, '0, '0, RESP_OKAY);
		add_entry(OP_WRITE, TIMER_BASE + MTIMECMP_LO, 32'h1234_5678, 4'hf, '0, RESP_OKAY);
		add_entry(OP_WRITE, TIMER_BASE + MTIMECMP_HI, 32'h0000_00ab, 4'hf, '0, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + MTIMECMP_LO, '0, '0, 32'h1234_5678, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + MTIMECMP_HI, '0, '0, 32'h0000_00ab, RESP_OKAY);
		add_entry(OP_READ, TIMER_BASE + 32'h4, '0, '0, '0, RESP_OKAY);
		cycle_limit = 40 * tbl.size() + 4 * CLK_MHZ * 64 + 200;

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if ({axil_rsp.awready, axil_rsp.wready, axil_rsp.arready, axil_rsp.bvalid,
			axil_rsp.rvalid, timer_irq} !== 6'b0) begin
			report_mismatch("awready/wready/arready/bvalid/rvalid/timer_irq",
				data_t'({axil_rsp.awready, axil_rsp.wready, axil_rsp.arready,
				axil_rsp.bvalid, axil_rsp.rvalid, timer_irq}), '0);
		end
		finish_test("reset state");
		foreach (tbl[i]) begin
			run_entry(tbl[i]);
			if (tbl[i].op != OP_IDLE) begin
				finish_test($sformatf("entry %0d at address %08h", i, tbl[i].addr));
			end
		end

		// Interrupt once mtime reaches 20
		bus_xfer(1'b1, TIMER_BASE + MTIMECMP_LO, 32'd20, 4'hf, rdata, resp);
		bus_xfer(1'b1, TIMER_BASE + MTIMECMP_HI, 32'd0, 4'hf, rdata, resp);
		bus_xfer(1'b1, TIMER_BASE + TIMER_CTRL, 32'd1, 4'hf, rdata, resp);
		wait_n = 0;
		do begin
			@(negedge clk);
			wait_n++;
		end while (!timer_irq && wait_n < 4 * CLK_MHZ * 32);
		if (!timer_irq) report_error("timer_irq never rose after the timer was enabled");
		bus_xfer(1'b0, TIMER_BASE + MTIME_LO, '0, '0, rdata, resp);
		if (rdata < 32'd20) begin
			$display("[FAIL] time %0t: mtime got %0d expected at least 20", $time, rdata);
			test_errs++;
		end
		finish_test("timer interrupt raise");
		bus_xfer(1'b1, TIMER_BASE + MTIMECMP_LO, 32'hffff_ffff, 4'hf, rdata, resp);
		bus_xfer(1'b1, TIMER_BASE + MTIMECMP_HI, 32'hffff_ffff, 4'hf, rdata, resp);
		wait_n = 0;
		do begin
			@(negedge clk);
			wait_n++;
		end while (timer_irq && wait_n < 4);
		if (timer_irq) report_error("timer_irq still high after mtimecmp was raised");
		finish_test("timer interrupt clear");

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
hdl/soc_pkg.sv
hdl/axil_decoder.sv
hdl/sram_store.sv
hdl/mtimer.sv
hdl/soc_top.sv
tests/tb_soc_top.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_soc_top -Mdir obj_dir -o sim_tb \
	&& out="$(./obj_dir/sim_tb)" \
	|| { echo "Build or simulation failed"; exit 1; }
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
